// File: hw/dma_spi_pkg.sv
/*
 * shared widths and depths for the DMA SPI controller
 * SPI instruction bytes and the two transfer mode codes
 * host register select encoding
 * configuration and SPI pin bundles
 */
package dma_spi_pkg;

	localparam int data_w     = 8;   // byte width
	localparam int chan_n     = 4;   // I/O channels
	localparam int cnt_w      = 4;   // byte count width
	localparam int fifo_depth = 16;  // power of two
	localparam int sclk_div   = 2;   // clk cycles per sclk half period

	localparam logic [data_w-1:0] op_read  = 8'h01;
	localparam logic [data_w-1:0] op_write = 8'h02;

	localparam logic [3:0] mode_mem_to_io = 4'b1001;
	localparam logic [3:0] mode_io_to_mem = 4'b0110;

	typedef enum logic [1:0] {
		sel_addr  = 2'd0,
		sel_count = 2'd1,
		sel_mode  = 2'd3
	} reg_sel_e;

	typedef struct packed {
		logic [data_w-1:0] addr;   // memory start address
		logic [cnt_w-1:0]  count;  // bytes to move
		logic [3:0]        mode;
	} dma_cfg_t;

	typedef struct packed {
		logic            sclk;
		logic            mosi;
		logic [chan_n:0] ss;  // active low, bit 0 memory, bit k+1 channel k
	} spi_pins_t;

endpackage

// File: hw/dma_cfg_regs.sv
/*
 * host configuration registers
 * address, byte count and mode, loaded through the 8-bit
 * data port while the bus is not granted
 */
module dma_cfg_regs (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           bgnt,
	input  logic [1:0]                     ds,
	input  logic [dma_spi_pkg::data_w-1:0] data,
	output dma_spi_pkg::dma_cfg_t          cfg
);

	import dma_spi_pkg::*;

	// --------------------------------------------------
	// register write, one register per clk
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cfg <= '0;  // mode 0 is invalid, nothing starts
		end else if (!bgnt) begin
			case (reg_sel_e'(ds))
				sel_addr: begin
					cfg.addr <= data;
				end
				sel_count: begin
					cfg.count <= data[cnt_w-1:0];  // upper bits ignored
				end
				sel_mode: begin
					cfg.mode <= data[3:0];
				end
				default: begin
					cfg <= cfg;  // code 2'b10 selects nothing
				end
			endcase
		end
	end

endmodule

// File: hw/dma_arbiter.sv
/*
 * fixed-priority DMA request resolver
 * channel 0 has the highest priority, the grant is frozen
 * while the bus is granted
 * bus request and active-low acknowledge
 */
module dma_arbiter (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [dma_spi_pkg::chan_n-1:0] dreq,
	input  logic                           bgnt,
	output logic [dma_spi_pkg::chan_n-1:0] grant,
	output logic [dma_spi_pkg::chan_n-1:0] dack,
	output logic                           breq
);

	import dma_spi_pkg::*;

	logic [chan_n-1:0] pick;  // one-hot winner of the current requests
	logic              pr_en;

	// isolate the lowest set request bit
	assign pick  = dreq & (~dreq + chan_n'(1));
	assign pr_en = !bgnt && (|dreq);  // resolve only off the bus

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			grant <= '0;
		end else if (pr_en) begin
			grant <= pick;
		end
	end

	// --------------------------------------------------
	// host side handshake levels
	// --------------------------------------------------
	assign breq = |grant;
	assign dack = bgnt ? ~grant : '1;  // low only for the served channel

endmodule

// File: hw/spi_byte_engine.sv
/*
 * SPI mode 0 byte engine
 * sclk divider that runs only while shifting
 * byte shift-out register, MSB first on falling edges
 * byte shift-in register sampled on rising edges
 */
module spi_byte_engine #(
	parameter int sclk_div = dma_spi_pkg::sclk_div
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           tx_load,
	input  logic [dma_spi_pkg::data_w-1:0] tx_byte,
	input  logic                           tx_start,
	input  logic                           rx_start,
	input  logic                           miso,
	output logic                           sclk,
	output logic                           mosi,
	output logic [dma_spi_pkg::data_w-1:0] rx_byte,
	output logic                           byte_done
);

	import dma_spi_pkg::*;

	localparam int div_w = (sclk_div > 1) ? $clog2(sclk_div) : 1;
	localparam int bit_w = $clog2(data_w);

	logic              active;   // byte in flight
	logic [div_w-1:0]  div_cnt;
	logic [bit_w-1:0]  bit_cnt;  // bits completed
	logic              tick;     // sclk phase boundary
	logic [data_w-1:0] tx_sr;
	logic [data_w-1:0] rx_sr;

	assign tick    = active && (div_cnt == div_w'(sclk_div - 1));
	assign mosi    = tx_sr[data_w-1];
	assign rx_byte = rx_sr;

	// --------------------------------------------------
	// divider, bit counter and sclk
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			active    <= 1'b0;
			div_cnt   <= '0;
			bit_cnt   <= '0;
			sclk      <= 1'b0;
			byte_done <= 1'b0;
		end else begin
			byte_done <= 1'b0;
			if (!active) begin
				if (tx_start || rx_start) begin
					active  <= 1'b1;
					div_cnt <= '0;
					bit_cnt <= '0;
				end
			end else if (tick) begin
				div_cnt <= '0;
				sclk    <= ~sclk;
				if (sclk) begin  // falling edge closes a bit
					if (bit_cnt == bit_w'(data_w - 1)) begin
						active    <= 1'b0;
						byte_done <= 1'b1;
					end else begin
						bit_cnt <= bit_cnt + bit_w'(1);
					end
				end
			end else begin
				div_cnt <= div_cnt + div_w'(1);
			end
		end
	end

	// --------------------------------------------------
	// shift registers
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (tx_load) begin
			tx_sr <= tx_byte;
		end else if (rx_start && !active) begin
			tx_sr <= '0;  // mosi idles low on reads
		end else if (tick && sclk) begin
			tx_sr <= {tx_sr[data_w-2:0], 1'b0};
		end
		if (tick && !sclk) begin
			rx_sr <= {rx_sr[data_w-2:0], miso};  // sample with sclk rising
		end
	end

endmodule

// File: hw/byte_fifo.sv
/*
 * synchronous byte FIFO
 * circular buffer with wrap-bit pointers and a registered read,
 * rd_data is valid the cycle after rd_en
 */
module byte_fifo #(
	parameter int fifo_depth = dma_spi_pkg::fifo_depth
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           wr_en,
	input  logic [dma_spi_pkg::data_w-1:0] wr_data,
	input  logic                           rd_en,
	output logic [dma_spi_pkg::data_w-1:0] rd_data,
	output logic                           empty
);

	import dma_spi_pkg::*;

	localparam int ptr_w = $clog2(fifo_depth);

	logic [data_w-1:0] mem [fifo_depth];
	logic [ptr_w:0]    wr_ptr;  // msb is the wrap bit
	logic [ptr_w:0]    rd_ptr;
	logic              do_rd;

	assign empty = (wr_ptr == rd_ptr);
	assign do_rd = rd_en && !empty;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + (ptr_w + 1)'(1);
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + (ptr_w + 1)'(1);
			end
		end
	end

	// storage and read register
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr[ptr_w-1:0]] <= wr_data;
		end
		if (do_rd) begin
			rd_data <= mem[rd_ptr[ptr_w-1:0]];
		end
	end

endmodule

// File: hw/dma_sequencer.sv
/*
 * DMA transfer FSM
 * source phase fills the FIFO from memory or a device,
 * sink phase drains it to the other side
 * one slave-select frame per byte, instruction, address, data
 */
module dma_sequencer (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           bgnt,
	input  dma_spi_pkg::dma_cfg_t          cfg,
	input  logic [dma_spi_pkg::chan_n-1:0] grant,
	input  logic                           byte_done,
	input  logic [dma_spi_pkg::data_w-1:0] rx_byte,
	input  logic [dma_spi_pkg::data_w-1:0] fifo_rd_data,
	input  logic                           fifo_empty,
	output logic [dma_spi_pkg::chan_n:0]   ss,
	output logic                           tx_load,
	output logic [dma_spi_pkg::data_w-1:0] tx_byte,
	output logic                           tx_start,
	output logic                           rx_start,
	output logic                           fifo_wr,
	output logic                           fifo_rd,
	output logic                           dma_busy,
	output logic                           dma_done
);

	import dma_spi_pkg::*;

	typedef enum logic [2:0] {
		st_idle, st_sel, st_load, st_start, st_wait, st_fetch, st_gap, st_done
	} state_e;

	typedef enum logic [1:0] {
		kind_cmd, kind_addr, kind_data
	} kind_e;

	state_e            state;
	kind_e             kind;         // byte within the frame
	logic              sink;         // second phase
	logic              m2i;          // memory-to-I/O transfer
	logic [cnt_w-1:0]  frames_left;
	logic [data_w-1:0] addr_ptr;
	logic              mem_frame;
	logic              mode_ok;

	assign mode_ok   = (cfg.mode == mode_mem_to_io) || (cfg.mode == mode_io_to_mem);
	assign mem_frame = m2i ^ sink;  // memory is read first in m2i, written last otherwise

	// --------------------------------------------------
	// strobes and status
	// --------------------------------------------------
	assign tx_load  = (state == st_load);
	assign tx_start = (state == st_start) && ((kind != kind_data) || sink);
	assign rx_start = (state == st_start) && (kind == kind_data) && !sink;
	assign fifo_rd  = (state == st_fetch);
	assign fifo_wr  = (state == st_wait) && byte_done && (kind == kind_data) && !sink;
	assign dma_done = (state == st_done);
	assign dma_busy = bgnt && (state != st_idle) && (state != st_done);

	// byte path, also carries received data into the FIFO
	always_comb begin
		case (kind)
			kind_cmd:  tx_byte = sink ? op_write : op_read;
			kind_addr: tx_byte = addr_ptr;
			default:   tx_byte = sink ? fifo_rd_data : rx_byte;
		endcase
	end

	// --------------------------------------------------
	// frame sequencing
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state       <= st_idle;
			kind        <= kind_cmd;
			sink        <= 1'b0;
			m2i         <= 1'b0;
			frames_left <= '0;
			addr_ptr    <= '0;
			ss          <= '1;
		end else if (!bgnt) begin
			state <= st_idle;  // bus withdrawn or transfer acknowledged
			ss    <= '1;
		end else begin
			case (state)
				st_idle: begin
					if (mode_ok) begin
						m2i         <= (cfg.mode == mode_mem_to_io);
						sink        <= 1'b0;
						frames_left <= cfg.count;
						addr_ptr    <= cfg.addr;
						state       <= st_sel;
					end
				end
				st_sel: begin
					ss          <= mem_frame ? {{chan_n{1'b1}}, 1'b0} : ~{grant, 1'b0};
					frames_left <= frames_left - cnt_w'(1);
					kind        <= kind_cmd;
					state       <= st_load;
				end
				st_load: state <= st_start;
				st_start: state <= st_wait;
				st_wait: begin
					if (byte_done) begin
						if (kind == kind_data) begin
							state <= st_gap;
						end else if ((kind == kind_cmd) && mem_frame) begin
							kind  <= kind_addr;
							state <= st_load;
						end else begin
							kind  <= kind_data;
							state <= sink ? st_fetch : st_start;  // reads skip the load
						end
						if (kind == kind_addr) begin
							addr_ptr <= addr_ptr + data_w'(1);
						end
					end
				end
				st_fetch: state <= st_load;  // FIFO read latency
				st_gap: begin
					ss <= '1;
					if (!sink && (frames_left == '0)) begin
						sink     <= 1'b1;
						addr_ptr <= cfg.addr;
						state    <= st_sel;
					end else if (sink && fifo_empty) begin
						state <= st_done;
					end else begin
						state <= st_sel;
					end
				end
				st_done: state <= st_done;  // held until bgnt falls
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// File: hw/dma_spi_master.sv
/*
 * DMA SPI controller top level
 * configuration registers, arbiter, sequencer,
 * SPI byte engine and byte FIFO
 */
module dma_spi_master #(
	parameter int fifo_depth = dma_spi_pkg::fifo_depth,
	parameter int sclk_div   = dma_spi_pkg::sclk_div
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [dma_spi_pkg::data_w-1:0] data,
	input  logic [1:0]                     ds,
	input  logic                           bgnt,
	output logic                           breq,
	output logic [dma_spi_pkg::chan_n-1:0] dack,
	output logic                           dma_busy,
	output logic                           dma_done,
	input  logic [dma_spi_pkg::chan_n-1:0] dreq,
	input  logic                           miso,
	output dma_spi_pkg::spi_pins_t         spi
);

	import dma_spi_pkg::*;

	dma_cfg_t          cfg;
	logic [chan_n-1:0] grant;
	logic [chan_n:0]   ss;
	logic              sclk;
	logic              mosi;
	logic              tx_load;
	logic [data_w-1:0] tx_byte;  // engine load data and FIFO write data
	logic              tx_start;
	logic              rx_start;
	logic [data_w-1:0] rx_byte;
	logic              byte_done;
	logic              fifo_wr;
	logic              fifo_rd;
	logic [data_w-1:0] fifo_rd_data;
	logic              fifo_empty;

	dma_cfg_regs i_cfg (
		.clk, .rst, .bgnt, .ds, .data, .cfg
	);

	dma_arbiter i_arb (
		.clk, .rst, .dreq, .bgnt, .grant, .dack, .breq
	);

	dma_sequencer i_seq (
		.clk, .rst, .bgnt, .cfg, .grant, .byte_done, .rx_byte, .fifo_rd_data,
		.fifo_empty, .ss, .tx_load, .tx_byte, .tx_start, .rx_start, .fifo_wr,
		.fifo_rd, .dma_busy, .dma_done
	);

	spi_byte_engine #(.sclk_div(sclk_div)) i_eng (
		.clk, .rst, .tx_load, .tx_byte, .tx_start, .rx_start, .miso,
		.sclk, .mosi, .rx_byte, .byte_done
	);

	byte_fifo #(.fifo_depth(fifo_depth)) i_fifo (
		.clk, .rst, .wr_en(fifo_wr), .wr_data(tx_byte), .rd_en(fifo_rd),
		.rd_data(fifo_rd_data), .empty(fifo_empty)
	);

	assign spi = '{sclk: sclk, mosi: mosi, ss: ss};

endmodule

// File: sim/spi_device_model.sv
/*
 * behavioral SPI mode 0 devices
 * 256-byte memory, frames of instruction, address, data
 * four I/O devices, frames of instruction, data,
 * with a read sequence and a write log per device
 */
module spi_device_model (
	input  dma_spi_pkg::spi_pins_t spi,
	output logic                   miso = 1'b0
);

	timeunit 1ns;
	timeprecision 1ns;

	import dma_spi_pkg::*;

	logic [data_w-1:0] mem [256];
	logic [data_w-1:0] io_log [chan_n][256];
	int                io_wr_n [chan_n] = '{default: 0};
	int                io_rd_n [chan_n] = '{default: 0};
	logic              frame;
	logic              frame_q = 1'b0;
	logic              sclk_q = 1'b0;
	int                sel;     // 0 memory, k+1 channel k
	int                bit_n;   // bits seen in this frame
	int                dstart;  // first data bit
	logic [data_w-1:0] sr;
	logic [data_w-1:0] cmd;
	logic [data_w-1:0] addr;
	logic [data_w-1:0] out_b;

	assign frame = ~&spi.ss;

	initial begin
		#1;  // after the testbench seeds the generator
		for (int i = 0; i < 256; i++) begin
			mem[i] = data_w'($urandom);
		end
	end

	always @(frame or spi.sclk) begin
		if (frame && !frame_q) begin
			bit_n = 0;
			cmd   = '0;
			for (int k = 0; k <= chan_n; k++) begin
				if (!spi.ss[k]) sel = k;
			end
			dstart = (sel == 0) ? 16 : 8;
		end else if (!frame && frame_q) begin
			if (sel > 0 && cmd == op_read) io_rd_n[sel-1]++;  // next read byte
		end else if (frame && spi.sclk && !sclk_q) begin
			sr = {sr[data_w-2:0], spi.mosi};
			bit_n++;
			if (bit_n == 8) begin
				cmd = sr;
			end else if (bit_n == 16 && sel == 0) begin
				addr = sr;
			end else if (bit_n == dstart + 8 && cmd == op_write) begin
				if (sel == 0) begin
					mem[addr] = sr;
				end else begin
					io_log[sel-1][io_wr_n[sel-1] % 256] = sr;
					io_wr_n[sel-1]++;
				end
			end
		end else if (frame && !spi.sclk && sclk_q) begin
			if (cmd == op_read && bit_n >= dstart && bit_n < dstart + 8) begin
				if (sel == 0) out_b = mem[addr];
				else out_b = data_w'((sel - 1) * 16 + io_rd_n[sel-1]) ^ 8'h5A;
				miso = out_b[7 - (bit_n % 8)];  // MSB first
			end
		end
		frame_q = frame;
		sclk_q  = spi.sclk;
	end

endmodule

// File: sim/dma_spi_checker.sv
/*
 * bound assertions on the DMA SPI top level
 * one slave select and one acknowledge at a time,
 * busy only while the bus is held across clk edges
 */
module dma_spi_checker (
	input logic                           clk,
	input logic                           rst,
	input logic [dma_spi_pkg::chan_n:0]   ss,
	input logic [dma_spi_pkg::chan_n-1:0] dack,
	input logic                           dma_busy,
	input logic                           bgnt
);

	timeunit 1ns;
	timeprecision 1ns;

	int fails = 0;  // read by the testbench at the end

	assert property (@(posedge clk) disable iff (!rst) $onehot0(~ss))
		else begin
			$error("more than one slave select low");
			fails++;
		end
	assert property (@(posedge clk) disable iff (!rst) $onehot0(~dack))
		else begin
			$error("more than one dack low");
			fails++;
		end
	// a transfer starts only on an edge that already saw bgnt high
	assert property (@(posedge clk) disable iff (!rst) dma_busy |-> bgnt && $past(bgnt))
		else begin
			$error("dma_busy without a held bgnt");
			fails++;
		end

endmodule

bind dma_spi_master dma_spi_checker i_chk (
	.clk, .rst, .ss(spi.ss), .dack, .dma_busy, .bgnt
);

// File: sim/tb_dma_spi.sv
/*
 * testbench for the DMA SPI controller
 * clock, reset, host stimulus and bus-grant model
 * reference I/O byte function and compare tasks
 * watchdog bounded by the worst-case transfer length
 */
module tb_dma_spi;

	timeunit 1ns;
	timeprecision 1ns;

	import dma_spi_pkg::*;

	localparam int tests    = 6;
	localparam int wait_lim = 2 * 15 * 3 * 32 * 2;  // cycles per transfer

	logic              clk;
	logic              rst;
	logic              bgnt;
	logic              miso;
	logic              breq;
	logic              dma_busy;
	logic              dma_done;
	logic [data_w-1:0] data;
	logic [1:0]        ds;
	logic [chan_n-1:0] dreq;
	logic [chan_n-1:0] dack;
	spi_pins_t         spi;
	int                errors = 0;
	int                test_errs = 0;
	int                test_n = 0;
	int                rd_seen [chan_n] = '{default: 0};
	logic [data_w-1:0] snap [256];

	dma_spi_master i_dut (
		.clk, .rst, .data, .ds, .bgnt, .breq, .dack, .dma_busy, .dma_done,
		.dreq, .miso, .spi
	);

	spi_device_model i_dev (.spi, .miso);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		repeat (tests * 2 * 15 * 3 * 32 + 2000) @(posedge clk);
		$display("watchdog expired, the run did not finish in time");
		$display("ERRORS FOUND");
		$finish;
	end

	// expected byte of the i-th read from device k
	function automatic logic [data_w-1:0] ref_io_byte(int k, int i);
		return data_w'(k * 16 + i) ^ 8'h5A;
	endfunction

	task automatic check_byte(input logic [data_w-1:0] got, exp, input string what);
		if (got !== exp) begin
			$display("FAIL %0t ns: %s got %h expected %h", $time, what, got, exp);
			errors++;
			test_errs++;
		end
	endtask

	task automatic check_flags(input logic [chan_n+2:0] got, exp, input string what);
		if (got !== exp) begin
			$display("FAIL %0t ns: %s got %b expected %b", $time, what, got, exp);
			errors++;
			test_errs++;
		end
	endtask

	task automatic check_ss(input logic [chan_n:0] got, exp, input string what);
		if (got !== exp) begin
			$display("FAIL %0t ns: %s got %b expected %b", $time, what, got, exp);
			errors++;
			test_errs++;
		end
	endtask

	task automatic step();
		@(posedge clk);
		#10;
	endtask

	task automatic load_cfg(input int a, cnt, input logic [3:0] mode);
		ds   = sel_addr;
		data = data_w'(a);
		step();
		ds   = sel_count;
		data = data_w'(cnt);
		step();
		ds   = sel_mode;
		data = {4'b0, mode};
		step();
	endtask

	// bus-grant model that grants once breq is seen
	task automatic take_bus(input logic [chan_n-1:0] req);
		int n;
		n    = 0;
		dreq = req;
		step();
		while (!breq && n < 20) begin
			step();
			n++;
		end
		if (!breq) begin
			$display("breq never rose for requests %b", req);
			errors++;
			test_errs++;
		end
		bgnt = 1'b1;
		step();
		dreq = '0;
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		while (!dma_done && n < wait_lim) begin
			step();
			n++;
		end
		if (!dma_done) begin
			$display("dma_done did not rise within %0d cycles", wait_lim);
			errors++;
			test_errs++;
		end
	endtask

	task automatic drop_bus();
		bgnt = 1'b0;
		step();
		check_flags({breq, dma_busy, dma_done, dack}, {3'b100, {chan_n{1'b1}}}, "released");
		check_ss(spi.ss, '1, "ss after release");
	endtask

	task automatic end_test(input string name);
		test_n++;
		$display("test %0d %s: %s", test_n, name, (test_errs == 0) ? "ok" : "failed");
		test_errs = 0;
	endtask

	task automatic run_m2i(input int k);
		int a;
		int cnt;
		int start;
		a     = $urandom % 256;
		cnt   = 1 + $urandom % 15;
		start = i_dev.io_wr_n[k];
		for (int i = 0; i < 256; i++) snap[i] = i_dev.mem[i];
		load_cfg(a, cnt, mode_mem_to_io);
		take_bus(~((chan_n'(1) << k) - chan_n'(1)));  // channels k and up request
		check_flags({breq, dma_busy, dma_done, dack}, {3'b110, ~(chan_n'(1) << k)},
			"flags at start");
		wait_done();
		check_flags({breq, dma_busy, dma_done, dack}, {3'b101, ~(chan_n'(1) << k)},
			"flags at done");
		check_byte(data_w'(i_dev.io_wr_n[k] - start), data_w'(cnt), "bytes written");
		for (int i = 0; i < cnt; i++) begin
			check_byte(i_dev.io_log[k][(start + i) % 256], snap[(a + i) % 256], "device log");
		end
		drop_bus();
	endtask

	task automatic run_i2m(input int k);
		int a;
		int cnt;
		int off;
		logic [data_w-1:0] exp;
		a   = $urandom % 256;
		cnt = 1 + $urandom % 15;
		for (int i = 0; i < 256; i++) snap[i] = i_dev.mem[i];
		load_cfg(a, cnt, mode_io_to_mem);
		take_bus(~((chan_n'(1) << k) - chan_n'(1)));
		check_flags({breq, dma_busy, dma_done, dack}, {3'b110, ~(chan_n'(1) << k)},
			"flags at start");
		wait_done();
		check_flags({breq, dma_busy, dma_done, dack}, {3'b101, ~(chan_n'(1) << k)},
			"flags at done");
		for (int j = 0; j < 256; j++) begin
			off = (j - a + 256) % 256;
			exp = (off < cnt) ? ref_io_byte(k, rd_seen[k] + off) : snap[j];
			check_byte(i_dev.mem[j], exp, $sformatf("memory byte %0d", j));
		end
		rd_seen[k] += cnt;
		drop_bus();
	endtask

	initial begin
		void'($urandom(19));
		rst  = 1'b0;
		bgnt = 1'b0;
		dreq = '0;
		ds   = '0;
		data = '0;
		repeat (4) @(posedge clk);
		#10 rst = 1'b1;
		step();

		check_flags({breq, dma_busy, dma_done, dack}, {3'b000, {chan_n{1'b1}}}, "reset");
		check_ss(spi.ss, '1, "ss after reset");
		end_test("reset values");

		take_bus(4'b1110);  // mode still invalid so nothing starts
		check_flags({breq, dma_busy, dma_done, dack}, {3'b100, 4'b1101}, "priority dack");
		drop_bus();
		end_test("priority");

		run_m2i(2);
		end_test("memory to io");

		run_i2m(1);
		end_test("io to memory");

		load_cfg(8'h10, 5, 4'b0011);
		take_bus(4'b1000);
		repeat (200) begin
			step();
			check_ss(spi.ss, '1, "ss with invalid mode");
			check_flags({breq, dma_busy, dma_done, dack}, {3'b100, 4'b0111}, "invalid mode");
		end
		drop_bus();
		end_test("invalid mode");

		run_m2i(0);
		run_i2m(3);
		end_test("back to back");

		errors += i_dut.i_chk.fails;
		$display("tests %0d, errors %0d", test_n, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: list.f
hw/dma_spi_pkg.sv
hw/dma_cfg_regs.sv
hw/dma_arbiter.sv
hw/spi_byte_engine.sv
hw/byte_fifo.sv
hw/dma_sequencer.sv
hw/dma_spi_master.sv
sim/spi_device_model.sv
sim/dma_spi_checker.sv
sim/tb_dma_spi.sv

// File: Makefile
.PHONY: all run lint clean

all: run

obj_dir/Vtb_dma_spi: list.f hw/*.sv sim/*.sv
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tb_dma_spi -f list.f

run: obj_dir/Vtb_dma_spi
	./obj_dir/Vtb_dma_spi | tee /dev/stderr | grep -q "NO ERRORS"

lint:
	verilator --lint-only --timing -Wall --top-module tb_dma_spi -f list.f

clean:
	rm -rf obj_dir
